//--- compile.f
+incdir+include
logic/posit_format_pkg.sv
logic/posit_accum_pkg.sv
logic/posit_decoder.sv
logic/leading_one_detector.sv
logic/posit_accumulator.sv
logic/posit_encoder.sv
logic/posit_accum_top.sv
verif/posit_accum_sva.sv
verif/posit_accum_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the posit accumulator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module posit_accum_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/Vposit_accum_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

//--- verif/posit_accum_tb.sv
/* Testbench for the posit16 accumulator; expected results come from a real-valued lane model.
   Operands are small integers and quarter fractions, so every model sum stays exact. */
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_accum_tb;

    localparam int LATENCY = 10;
    localparam int CHAIN_LEN = 24;
    // Reset release, chain, interleave, zero/NaR, saturation, ties, drain
    localparam int TEST_CYCLES = 2 + CHAIN_LEN * 8 + 32 + 40 + 32 + 32 + LATENCY + 2;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 50;
    localparam int MEM_DEPTH = CYCLE_LIMIT + 20;

    logic                     clk;
    logic                     rst;
    posit_format_pkg::posit_t operand;
    logic                     start;
    logic                     clear;
    posit_format_pkg::posit_t result;
    logic                     done;

    int                       cyc;
    int                       seed;
    real                      lane_sum [0:`ACCUM_LAT-1];
    bit                       lane_nar [0:`ACCUM_LAT-1];
    posit_format_pkg::posit_t exp_mem [0:MEM_DEPTH-1];
    bit                       exp_valid [0:MEM_DEPTH-1];

    posit_accum_top uut (
        .clk     (clk),
        .rst     (rst),
        .operand (operand),
        .start   (start),
        .clear   (clear),
        .result  (result),
        .done    (done)
    );

    always #20 clk = ~clk;

    always @(posedge clk or posedge rst)
    begin
        if (rst)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    always @(posedge clk)
    begin
        if (cyc >= CYCLE_LIMIT)
        begin
            $display("Test failed");
            $fatal(1, "Timeout: the run did not finish within the cycle limit");
        end
    end

    // Software posit16 decode, es = 2
    function automatic real to_real(input posit_format_pkg::posit_t w);
        logic [15:0] m;
        int          i;
        int          run;
        int          k;
        int          e;
        real         frac;
        real         wgt;
        begin
            if (w == 16'h0000)
                return 0.0;
            m = w[15] ? -w : w;
            i = 14;
            run = 0;
            while (i >= 0 && m[i] == m[14])
            begin
                run++;
                i--;
            end
            k = m[14] ? run - 1 : -run;
            i--;
            e = 0;
            repeat (2)
            begin
                e = e * 2 + ((i >= 0) ? int'(m[i]) : 0);
                i--;
            end
            frac = 1.0;
            wgt = 0.5;
            while (i >= 0)
            begin
                if (m[i])
                    frac = frac + wgt;
                wgt = wgt / 2.0;
                i--;
            end
            frac = frac * (2.0 ** (4 * k + e));
            return w[15] ? -frac : frac;
        end
    endfunction

    // Software posit16 encode, round to nearest even, saturating
    function automatic posit_format_pkg::posit_t to_posit(input real x);
        logic [79:0] bits;
        logic [14:0] body;
        logic [15:0] mag;
        real         a;
        real         f;
        int          s;
        int          k;
        int          e;
        int          n;
        begin
            if (x == 0.0)
                return 16'h0000;
            a = (x < 0.0) ? -x : x;
            s = 0;
            while (a >= 2.0)
            begin
                a = a / 2.0;
                s++;
            end
            while (a < 1.0)
            begin
                a = a * 2.0;
                s--;
            end
            if (s >= 56)
                mag = 16'h7fff;
            else if (s < -56)
                mag = 16'h0001;
            else
            begin
                k = (s >= 0) ? s / 4 : -((-s + 3) / 4);
                e = s - 4 * k;
                bits = '0;
                n = 0;
                if (k >= 0)
                    n = k + 2;
                else
                    n = -k + 1;
                // Regime run then its terminator
                for (int j = 0; j < n - 1; j++)
                    bits[79-j] = (k >= 0);
                bits[80-n] = (k < 0);
                bits[79-n] = e[1];
                bits[78-n] = e[0];
                n = n + 2;
                f = a - 1.0;
                while (n < 80)
                begin
                    f = f * 2.0;
                    bits[79-n] = (f >= 1.0);
                    if (f >= 1.0)
                        f = f - 1.0;
                    n++;
                end
                body = bits[79:65];
                mag = {1'b0, body + 15'(bits[64] & ((|bits[63:0]) | (f != 0.0) | body[0]))};
            end
            return (x < 0.0) ? -mag : mag;
        end
    endfunction

    // Drive one operand and record the result the lane should produce
    task automatic issue(input posit_format_pkg::posit_t word, input bit clr);
        int lane;
        int slot;
        begin
            @(posedge clk);
            lane = cyc % `ACCUM_LAT;
            // Drive edge comes one edge before the DUT captures start
            slot = cyc + LATENCY + 1;
            operand <= word;
            start <= 1'b1;
            clear <= clr;
            if (clr)
            begin
                lane_sum[lane] = 0.0;
                lane_nar[lane] = 1'b0;
            end
            if (word == 16'h8000)
                lane_nar[lane] = 1'b1;
            else
                lane_sum[lane] = lane_sum[lane] + to_real(word);
            exp_mem[slot] = lane_nar[lane] ? 16'h8000 : to_posit(lane_sum[lane]);
            exp_valid[slot] = 1'b1;
        end
    endtask

    task automatic idle(input int n);
        begin
            repeat (n)
            begin
                @(posedge clk);
                start <= 1'b0;
                clear <= 1'b0;
            end
        end
    endtask

    function automatic real pick_value();
        int r;
        begin
            r = $random(seed) % 101;
            if (r % 3 == 0)
                return r / 4.0;
            return r;
        end
    endfunction

    assert property (@(posedge clk) disable iff (rst) done |-> result == exp_mem[cyc])
    else
    begin
        $display("CHECK FAILED result: got %h expected %h", $sampled(result),
                 exp_mem[$sampled(cyc)]);
        $display("Test failed");
        $fatal(1, "Result mismatch");
    end

    assert property (@(posedge clk) disable iff (rst) done == exp_valid[cyc])
    else
    begin
        $display("CHECK FAILED done: got %h expected %h", $sampled(done),
                 exp_valid[$sampled(cyc)]);
        $display("Test failed");
        $fatal(1, "Done strobe mismatch");
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        operand = '0;
        start = 1'b0;
        clear = 1'b0;
        seed = 66216;
        for (int i = 0; i < `ACCUM_LAT; i++)
        begin
            lane_sum[i] = 0.0;
            lane_nar[i] = 1'b0;
        end
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            exp_mem[i] = '0;
            exp_valid[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // One lane: sign change, cancellation, then random terms
        issue(to_posit(12.0), 1'b1);
        idle(7);
        issue(to_posit(-20.0), 1'b0);
        idle(7);
        issue(to_posit(8.0), 1'b0);
        idle(7);
        for (int i = 3; i < CHAIN_LEN; i++)
        begin
            issue(to_posit(pick_value()), 1'b0);
            idle(7);
        end

        // Eight lanes back to back
        for (int r = 0; r < 4; r++)
            for (int l = 0; l < `ACCUM_LAT; l++)
                issue(to_posit(pick_value()), r == 0);

        // Zero keeps the sum, NaR sticks until clear
        issue(to_posit(5.0), 1'b1);
        idle(7);
        issue(16'h0000, 1'b0);
        idle(7);
        issue(16'h8000, 1'b0);
        idle(7);
        issue(to_posit(3.0), 1'b0);
        idle(7);
        issue(to_posit(2.0), 1'b1);
        idle(7);

        // Saturation at maxpos, both signs
        issue(16'h7fff, 1'b1);
        idle(7);
        issue(16'h7fff, 1'b0);
        idle(7);
        issue(16'h8001, 1'b1);
        idle(7);
        issue(16'h8001, 1'b0);
        idle(7);

        // Ties near 4096 where the last fraction bit weighs 16
        issue(to_posit(4096.0), 1'b1);
        idle(7);
        issue(to_posit(8.0), 1'b0);
        idle(7);
        issue(to_posit(16.0), 1'b0);
        idle(7);
        issue(to_posit(-8.0), 1'b0);
        idle(7);

        idle(LATENCY + 2);
        $display("Test passed");
        $finish;
    end

endmodule

//--- verif/posit_accum_sva.sv
/* Start/done protocol and NaR lane checks for posit_accum_top.
   Assumes the fixed 10-cycle latency and no back-pressure. */
`timescale 1ns/1ps

module posit_accum_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     start,
    input logic                     clear,
    input logic                     done,
    input posit_format_pkg::posit_t result
);

    // Every operand produces a result 10 cycles on
    property start_gives_done;
        @(posedge clk) disable iff (rst) start |-> ##10 done;
    endproperty

    // No result without an operand 10 cycles back
    property done_needs_start;
        @(posedge clk) disable iff (rst) done |-> $past(start, 10);
    endproperty

    // A NaR lane stays NaR until an operand brings clear
    property nar_sticks;
        @(posedge clk) disable iff (rst)
            done && $past(done && result == 16'h8000, 8) && !$past(clear, 10)
                |-> result == 16'h8000;
    endproperty

    assert property (start_gives_done)
    else
        $error("done did not follow start after 10 cycles");

    assert property (done_needs_start)
    else
        $error("done rose without a start 10 cycles earlier");

    assert property (nar_sticks)
    else
        $error("lane left NaR without a clear");

endmodule

bind posit_accum_top posit_accum_sva protocol_check (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .clear  (clear),
    .done   (done),
    .result (result)
);

//--- logic/posit_accum_top.sv
/* Posit16 accumulator with eight interleaved lanes, no back-pressure.
   Start to done is 10 cycles; result is valid only while done is high. */
`timescale 1ns/1ps

module posit_accum_top (
    input  logic                     clk,
    input  logic                     rst,
    input  posit_format_pkg::posit_t operand,
    input  logic                     start,
    input  logic                     clear,
    output posit_format_pkg::posit_t result,
    output logic                     done
);

    posit_format_pkg::posit_value_t dec_value;
    logic                           dec_start;
    logic                           dec_clear;
    posit_accum_pkg::accum_value_t  acc_sum;
    logic                           acc_done;

    posit_decoder decoder (
        .clk         (clk),
        .rst         (rst),
        .operand     (operand),
        .start       (start),
        .clear       (clear),
        .value       (dec_value),
        .value_start (dec_start),
        .value_clear (dec_clear)
    );

    // Eight cycles from start to done, also the lane count
    posit_accumulator accumulator (
        .clk     (clk),
        .rst     (rst),
        .operand (dec_value),
        .start   (dec_start),
        .clear   (dec_clear),
        .sum     (acc_sum),
        .done    (acc_done)
    );

    posit_encoder encoder (
        .clk       (clk),
        .rst       (rst),
        .sum       (acc_sum),
        .sum_valid (acc_done),
        .result    (result),
        .done      (done)
    );

endmodule

//--- logic/posit_encoder.sv
/* Registered rounding of the wide sum to posit16, nearest with ties to even.
   Out-of-range sums saturate to maxpos or minpos, never to NaR or zero. */
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_encoder (
    input  logic                          clk,
    input  logic                          rst,
    input  posit_accum_pkg::accum_value_t sum,
    input  logic                          sum_valid,
    output posit_format_pkg::posit_t      result,
    output logic                          done
);

    localparam int BODY_W = `POSIT_N - 1;
    localparam int TAIL_W = `POSIT_ES + `FBITS_ACCUM;
    localparam int V_W = 2 + TAIL_W + BODY_W;
    localparam int AMT_W = $clog2(BODY_W);
    // Scale of maxpos, minpos is its negative
    localparam int MAX_SCALE = (`POSIT_N - 2) << `POSIT_ES;

    posit_format_pkg::scale_t k;
    logic [AMT_W-1:0]         amt;
    logic signed [V_W-1:0]    v;
    logic [V_W-1:0]           shifted;
    logic [BODY_W-1:0]        body;
    logic [BODY_W-1:0]        body_r;
    logic                     guard;
    logic                     sticky;
    posit_format_pkg::posit_t mag;
    posit_format_pkg::posit_t enc;

    always_comb
    begin
        // Regime value and run length beyond the first bit
        k = sum.scale >>> `POSIT_ES;
        amt = k[`SCALE_W-1] ? ~k[AMT_W-1:0] : k[AMT_W-1:0];

        // Arithmetic shift replicates the regime bit and keeps its terminator behind it
        v = {(k[`SCALE_W-1] ? 2'b01 : 2'b10), sum.scale[`POSIT_ES-1:0], sum.fraction,
             {BODY_W{1'b0}}};
        shifted = v >>> amt;

        body = shifted[V_W-1 -: BODY_W];
        guard = shifted[V_W-1-BODY_W];
        sticky = |shifted[V_W-2-BODY_W:0];
        body_r = body + BODY_W'(guard & (sticky | body[0]));

        if (sum.scale >= MAX_SCALE)
            mag = {1'b0, {BODY_W{1'b1}}};
        else if (sum.scale < -MAX_SCALE)
            mag = posit_format_pkg::posit_t'(1);
        else
            mag = {1'b0, body_r};

        if (sum.inf)
            enc = {1'b1, {BODY_W{1'b0}}};
        else if (sum.zero)
            enc = '0;
        else
            enc = sum.sgn ? -mag : mag;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            done <= 1'b0;
        else
            done <= sum_valid;
    end

    // Result holds its last value between strobes
    always_ff @(posedge clk)
    begin
        if (sum_valid)
            result <= enc;
    end

endmodule

//--- logic/posit_accumulator.sv
/* Eight-stage align/add/normalize loop holding eight interleaved lane sums.
   Alignment truncates bits below the wide fraction; NaR sticks until clear. */
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_accumulator (
    input  logic                           clk,
    input  logic                           rst,
    input  posit_format_pkg::posit_value_t operand,
    input  logic                           start,
    input  logic                           clear,
    output posit_accum_pkg::accum_value_t  sum,
    output logic                           done
);

    localparam posit_accum_pkg::accum_value_t ACC_ZERO = '{
        sgn: 1'b0, scale: '0, fraction: '0, inf: 1'b0, zero: 1'b1
    };
    localparam posit_accum_pkg::accum_value_t ACC_NAR = '{
        sgn: 1'b1, scale: '0, fraction: '0, inf: 1'b1, zero: 1'b0
    };
    localparam posit_accum_pkg::order_stage_t ORDER_ZERO = '{
        start: 1'b0, add: 1'b1, hi: ACC_ZERO, lo: ACC_ZERO
    };
    localparam int PAD_W = `FBITS_ACCUM - `FBITS;
    localparam int RAW_W = $bits(posit_accum_pkg::raw_sum_t);
    localparam int SCW = `SCALE_W + 2;
    localparam int SCALE_MAX = 2 ** (`SCALE_W - 1) - 1;
    // Leading one lands here after normalization
    localparam posit_accum_pkg::sum_pos_t TOP_POS = posit_accum_pkg::sum_pos_t'(RAW_W - 1);

    posit_accum_pkg::accum_value_t op_wide, r1_a, r1_b, r7, final_val;
    posit_accum_pkg::order_stage_t order, r2, r3;
    posit_accum_pkg::align_stage_t align, r4;
    posit_accum_pkg::sum_stage_t   added, adjusted, r5, r6;
    posit_accum_pkg::scale_diff_t  r3_diff;
    posit_accum_pkg::raw_sum_t     norm;
    posit_accum_pkg::sum_pos_t     lod_pos, r6_pos;
    logic                          lod_found, r6_zero, r1_start, r7_start, a_ge_b;
    logic signed [SCW-1:0]         scale_wide;

    // Stage 1: widen the operand, pick up the lane sum leaving the loop
    always_comb
    begin
        op_wide.sgn = operand.sgn;
        op_wide.scale = operand.scale;
        op_wide.fraction = {operand.fraction, {PAD_W{1'b0}}};
        op_wide.inf = operand.inf;
        op_wide.zero = operand.zero;
    end

    // Stage 2: order by magnitude, zero always the smaller
    assign a_ge_b = {~r1_a.zero, ~r1_a.scale[`SCALE_W-1], r1_a.scale[`SCALE_W-2:0], r1_a.fraction}
                 >= {~r1_b.zero, ~r1_b.scale[`SCALE_W-1], r1_b.scale[`SCALE_W-2:0], r1_b.fraction};
    assign order = '{start: r1_start, add: (r1_a.sgn == r1_b.sgn),
                     hi: a_ge_b ? r1_a : r1_b, lo: a_ge_b ? r1_b : r1_a};

    // Stage 4: align the smaller mantissa, nothing survives past full width
    always_comb
    begin
        align.start = r3.start;
        align.add = r3.add;
        align.sgn = r3.hi.sgn;
        align.inf = r3.hi.inf | r3.lo.inf;
        align.scale = r3.hi.scale;
        align.hi_mant = {1'b0, ~r3.hi.zero, r3.hi.fraction};
        align.lo_mant = (r3_diff >= RAW_W) ? '0 : {1'b0, ~r3.lo.zero, r3.lo.fraction} >> r3_diff;
    end

    // Stage 5: hi is never smaller, so the difference stays non-negative
    assign added = '{start: r4.start, sgn: r4.sgn, inf: r4.inf, scale: r4.scale,
                     raw: r4.add ? r4.hi_mant + r4.lo_mant : r4.hi_mant - r4.lo_mant};

    // Stage 6: move the scale by the distance of the leading one from the hidden bit
    leading_one_detector lod (
        .bits  (r5.raw),
        .pos   (lod_pos),
        .found (lod_found)
    );

    always_comb
    begin
        adjusted = r5;
        scale_wide = SCW'(r5.scale) + SCW'(lod_pos) - SCW'(`FBITS_ACCUM);
        if (scale_wide > SCALE_MAX)
            adjusted.scale = posit_format_pkg::scale_t'(SCALE_MAX);
        else if (scale_wide < -SCALE_MAX - 1)
            adjusted.scale = posit_format_pkg::scale_t'(-SCALE_MAX - 1);
        else
            adjusted.scale = scale_wide[`SCALE_W-1:0];
    end

    // Stage 7: put the leading one on top, the bit below it starts the fraction
    assign norm = r6.raw << (TOP_POS - r6_pos);

    // Stage 8: NaR wins over everything, zero gets a clean encoding
    always_comb
    begin
        final_val = r7;
        if (r7.inf)
            final_val = ACC_NAR;
        else if (r7.zero)
            final_val = ACC_ZERO;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            r1_start <= 1'b0;
            r1_a <= ACC_ZERO;
            r1_b <= ACC_ZERO;
            r2 <= ORDER_ZERO;
            r3 <= ORDER_ZERO;
            r3_diff <= '0;
            r4 <= '0;
            r5 <= '0;
            r6 <= '0;
            r6_pos <= '0;
            r6_zero <= 1'b1;
            r7_start <= 1'b0;
            r7 <= ACC_ZERO;
            done <= 1'b0;
            sum <= ACC_ZERO;
        end
        else
        begin
            r1_start <= start;
            r1_a <= start ? op_wide : ACC_ZERO;
            r1_b <= (start && clear) ? ACC_ZERO : sum;
            r2 <= order;
            r3 <= r2;
            r3_diff <= r2.hi.scale - r2.lo.scale;
            r4 <= align;
            r5 <= added;
            r6 <= adjusted;
            r6_pos <= lod_pos;
            r6_zero <= ~lod_found;
            r7_start <= r6.start;
            r7 <= '{sgn: r6.sgn, scale: r6.scale, fraction: norm[`FBITS_ACCUM:1],
                    inf: r6.inf, zero: r6_zero};
            done <= r7_start;
            sum <= final_val;
        end
    end

endmodule

//--- logic/leading_one_detector.sv
/* Priority encoder over the raw adder sum.
   pos is only meaningful while found is high. */
`timescale 1ns/1ps

module leading_one_detector (
    input  posit_accum_pkg::raw_sum_t bits,
    output posit_accum_pkg::sum_pos_t pos,
    output logic                      found
);

    always_comb
    begin
        pos = '0;
        found = 1'b0;
        // Later iterations overwrite, so the highest set bit wins
        for (int i = 0; i < $bits(bits); i++)
        begin
            if (bits[i])
            begin
                pos = posit_accum_pkg::sum_pos_t'(i);
                found = 1'b1;
            end
        end
    end

endmodule

//--- logic/posit_decoder.sv
/* Registered posit16 decode, one word per cycle.
   start and clear are delayed one cycle to line up with the value. */
`timescale 1ns/1ps
`include "posit_params.svh"

module posit_decoder (
    input  logic                           clk,
    input  logic                           rst,
    input  posit_format_pkg::posit_t       operand,
    input  logic                           start,
    input  logic                           clear,
    output posit_format_pkg::posit_value_t value,
    output logic                           value_start,
    output logic                           value_clear
);

    localparam int BODY_W = `POSIT_N - 1;
    localparam int RUN_W = $clog2(`POSIT_N);

    posit_format_pkg::posit_t       mag;
    logic [BODY_W-1:0]              body;
    logic [BODY_W-1:0]              tail;
    logic [RUN_W-1:0]               run;
    logic [RUN_W:0]                 cut;
    logic                           stop;
    posit_format_pkg::scale_t       run_s;
    posit_format_pkg::scale_t       regime;
    logic [`POSIT_ES-1:0]           expo;
    posit_format_pkg::posit_value_t dec;

    always_comb
    begin
        mag = operand[`POSIT_N-1] ? -operand : operand;
        body = mag[BODY_W-1:0];

        // Length of the regime run, counted from the top bit
        run = RUN_W'(1);
        stop = 1'b0;
        for (int i = BODY_W - 2; i >= 0; i--)
        begin
            if (!stop && body[i] == body[BODY_W-1])
                run = run + 1'b1;
            else
                stop = 1'b1;
        end

        // Drop the run and its terminating bit
        cut = {1'b0, run} + 1'b1;
        tail = body << cut;
        expo = tail[BODY_W-1 -: `POSIT_ES];

        run_s = {{(`SCALE_W-RUN_W){1'b0}}, run};
        regime = body[BODY_W-1] ? run_s - 8'sd1 : -run_s;

        dec.sgn = operand[`POSIT_N-1];
        dec.scale = (regime <<< `POSIT_ES) + {{(`SCALE_W-`POSIT_ES){1'b0}}, expo};
        dec.fraction = tail[BODY_W-1-`POSIT_ES -: `FBITS];
        dec.zero = (operand == '0);
        dec.inf = (operand == {1'b1, {BODY_W{1'b0}}});
        if (dec.zero || dec.inf)
        begin
            dec.scale = '0;
            dec.fraction = '0;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            value_start <= 1'b0;
            value_clear <= 1'b0;
        end
        else
        begin
            value_start <= start;
            value_clear <= clear;
        end
    end

    always_ff @(posedge clk)
    begin
        value <= dec;
    end

endmodule

//--- logic/posit_accum_pkg.sv
/* Types of the accumulator datapath and its pipeline stage records.
   The wide value uses the same scale encoding as the posit format. */
`include "posit_params.svh"

package posit_accum_pkg;

    // Wide fraction, hidden bit not included
    typedef logic [`FBITS_ACCUM-1:0] accum_fraction_t;

    // Carry, hidden bit and wide fraction
    typedef logic [`FBITS_ACCUM+1:0] raw_sum_t;

    // Bit index into raw_sum_t
    typedef logic [5:0] sum_pos_t;

    // Unsigned distance between two scales
    typedef logic [`SCALE_W-1:0] scale_diff_t;

    typedef struct packed {
        logic                     sgn;
        posit_format_pkg::scale_t scale;
        accum_fraction_t          fraction;
        logic                     inf;
        logic                     zero;
    } accum_value_t;

    // Operands ordered by magnitude
    typedef struct packed {
        logic         start;
        logic         add;
        accum_value_t hi;
        accum_value_t lo;
    } order_stage_t;

    // Mantissas aligned to the larger scale
    typedef struct packed {
        logic                     start;
        logic                     add;
        logic                     sgn;
        logic                     inf;
        posit_format_pkg::scale_t scale;
        raw_sum_t                 hi_mant;
        raw_sum_t                 lo_mant;
    } align_stage_t;

    // Unnormalized sum
    typedef struct packed {
        logic                     start;
        logic                     sgn;
        logic                     inf;
        posit_format_pkg::scale_t scale;
        raw_sum_t                 raw;
    } sum_stage_t;

endpackage

//--- logic/posit_format_pkg.sv
/* Types for the posit16 number format with es = 2.
   The serialized value drops the hidden bit of the fraction. */
`include "posit_params.svh"

package posit_format_pkg;

    // Raw posit word as it appears on the bus
    typedef logic [`POSIT_N-1:0] posit_t;

    // Regime times 2^es plus exponent, two's complement
    typedef logic signed [`SCALE_W-1:0] scale_t;

    // Fraction bits below the hidden one
    typedef logic [`FBITS-1:0] fraction_t;

    // Decoded posit
    // inf marks NaR, zero marks the zero word; other fields are
    // cleared for both
    typedef struct packed {
        logic      sgn;
        scale_t    scale;
        fraction_t fraction;
        logic      inf;
        logic      zero;
    } posit_value_t;

endpackage

//--- include/posit_params.svh
/* Widths for posit16 with es = 2 and the wide accumulator.
   The RTL supports only this posit size and es value. */
`ifndef POSIT_PARAMS_SVH
`define POSIT_PARAMS_SVH

// Posit word and exponent field
`define POSIT_N 16
`define POSIT_ES 2

// Signed scale, regime times 4 plus exponent
`define SCALE_W 8

// Fraction widths, hidden bit not counted
`define FBITS 11
`define FBITS_ACCUM 40

// Accumulator depth, also the number of interleaved lanes
`define ACCUM_LAT 8

`endif
